// File: logic/font5_io_pkg.sv
`default_nettype none

////////////////////
// Front end constants
////////////////////

package font5_io_pkg;

	// Board layout
	localparam int unsigned num_groups = 3; // ADC groups, three channels each

	// Variable delay lines
	localparam int unsigned tap_bits = 6; // 64 taps per line

	// Alignment monitor
	localparam int unsigned align_cnt_bits = 16;

	// Board-detect synchroniser depth
	localparam int unsigned sync_stages = 2;

	// Tap setting of one delay line
	typedef logic [tap_bits-1:0] tap_t;

	// Saturating disagreement count
	typedef logic [align_cnt_bits-1:0] align_cnt_t;

	localparam tap_t tap_max = tap_t'(63); // Last tap, next increment wraps to 0

endpackage

`default_nettype wire

// File: logic/idelay_tap_counter.sv
`timescale 1ns/1ps
`default_nettype none

// Shadow of one incrementing delay line tap setting
module idelay_tap_counter
	import font5_io_pkg::*;
(
	input  wire  clk357,
	input  wire  reset,
	input  wire  clear, // Delay calc strobe or delay trigger
	input  wire  ce,    // One tap step
	output tap_t tap
);

	////////////////////
	// Tap tracking
	////////////////////

	always_ff @(posedge clk357) begin
		if (reset) begin
			tap <= '0;
		end else if (clear) begin
			tap <= '0; // Line reset wins over a step
		end else if (ce) begin
			// Delay line rolls over past the last tap
			if (tap == tap_max) begin
				tap <= '0;
			end else begin
				tap <= tap + 1'b1;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Either reset source lands the tap at zero a cycle later
	a_tap_cleared: assert property (
		@(posedge clk357) (clear || reset) |=> (tap == '0)
	) else $error("tap not zero after clear or reset");

endmodule

`default_nettype wire

// File: logic/drdy_iddr.sv
`timescale 1ns/1ps
`default_nettype none

// Double-edge sampler for one data-ready line, both halves on the rising edge
module drdy_iddr (
	input  wire  clk357,
	input  wire  reset,
	input  wire  ce,
	input  wire  drdy,    // Straight from the pad, no relation to clk357
	output logic iddr_q1, // Late half, rising edge sample
	output logic iddr_q2  // Early half, falling edge sample
);

	logic fall_q; // Falling edge capture
	logic fall_r; // Falling sample moved onto the rising edge
	logic rise_q; // Rising edge capture

	////////////////////
	// Capture stage
	////////////////////

	// Half cycle after the rising edge
	always_ff @(negedge clk357) begin
		if (reset) begin
			fall_q <= 1'b0;
		end else if (ce) begin
			fall_q <= drdy;
		end
	end

	// Rising edge takes the late half and realigns the early half
	always_ff @(posedge clk357) begin
		if (reset) begin
			rise_q <= 1'b0;
			fall_r <= 1'b0;
		end else if (ce) begin
			rise_q <= drdy;
			fall_r <= fall_q;
		end
	end

	////////////////////
	// Output pair
	////////////////////

	always_ff @(posedge clk357) begin
		if (reset) begin
			iddr_q1 <= 1'b0;
			iddr_q2 <= 1'b0;
		end else if (ce) begin
			iddr_q1 <= rise_q; // Same cycle as fall_r
			iddr_q2 <= fall_r;
		end
	end

	// With ce low the whole pipe is frozen, outputs included
	a_hold_on_ce_low: assert property (
		@(posedge clk357) disable iff (reset)
		(!ce && !reset) |=> ($stable(iddr_q1) && $stable(iddr_q2))
	) else $error("sampler outputs moved while ce was low");

endmodule

`default_nettype wire

// File: logic/drdy_align_monitor.sv
`timescale 1ns/1ps
`default_nettype none

// Counts cycles where the drdy edge fell between the two sampling edges
module drdy_align_monitor
	import font5_io_pkg::*;
(
	input  wire        clk357,
	input  wire        reset,
	input  wire        clear,   // Delay calc strobe of this group
	input  wire        iddr_q1, // Late half
	input  wire        iddr_q2, // Early half
	output align_cnt_t align_count
);

	logic mismatch;

	// Halves differ, so the transition sat inside this clock cycle
	assign mismatch = iddr_q1 ^ iddr_q2;

	////////////////////
	// Counter
	////////////////////

	always_ff @(posedge clk357) begin
		if (reset) begin
			align_count <= '0;
		end else if (clear) begin
			align_count <= '0; // New calibration pass
		end else if (mismatch && (align_count != '1)) begin
			align_count <= align_count + 1'b1; // Stick at full scale
		end
	end

	// Calibration reads the count as monotonic between clears
	a_no_decrease: assert property (
		@(posedge clk357) disable iff (reset)
		(!clear && !reset) |=> (align_count >= $past(align_count))
	) else $error("alignment count went down without a clear");

endmodule

`default_nettype wire

// File: logic/adc_group.sv
`timescale 1ns/1ps
`default_nettype none

// One ADC group: delay taps, drdy sampling, alignment count, gated clock
module adc_group
	import font5_io_pkg::*;
(
	input  wire        clk357,
	input  wire        reset,
	input  wire        run,             // Acquisition level
	input  wire        iddr_ce,
	input  wire        delay_calc_strb,
	input  wire        delay_trig,
	input  wire        clk_delay_ce,
	input  wire        drdy_delay_ce,
	input  wire        data_delay_ce,
	input  wire        drdy,            // Asynchronous data-ready line
	output logic       adc_clk,
	output tap_t       clk_tap,
	output tap_t       drdy_tap,
	output tap_t       data_tap,
	output logic       iddr_q1,
	output logic       iddr_q2,
	output align_cnt_t align_count
);

	logic delay_clr; // Common reset of the three delay lines
	logic run_n;     // run seen on the falling edge

	assign delay_clr = delay_calc_strb | delay_trig;

	////////////////////
	// Delay taps
	////////////////////

	idelay_tap_counter clk_tap_i ( // Outgoing ADC clock
		.clk357 (clk357),
		.reset  (reset),
		.clear  (delay_clr),
		.ce     (clk_delay_ce),
		.tap    (clk_tap)
	);

	idelay_tap_counter drdy_tap_i ( // Data-ready input
		.clk357 (clk357),
		.reset  (reset),
		.clear  (delay_clr),
		.ce     (drdy_delay_ce),
		.tap    (drdy_tap)
	);

	idelay_tap_counter data_tap_i ( // Data bus, one setting for all 13 bits
		.clk357 (clk357),
		.reset  (reset),
		.clear  (delay_clr),
		.ce     (data_delay_ce),
		.tap    (data_tap)
	);

	////////////////////
	// drdy sampling
	////////////////////

	drdy_iddr drdy_iddr_i (
		.clk357  (clk357),
		.reset   (reset),
		.ce      (iddr_ce),
		.drdy    (drdy),
		.iddr_q1 (iddr_q1),
		.iddr_q2 (iddr_q2)
	);

	drdy_align_monitor align_mon_i (
		.clk357      (clk357),
		.reset       (reset),
		.clear       (delay_calc_strb), // Only the calc strobe restarts the count
		.iddr_q1     (iddr_q1),
		.iddr_q2     (iddr_q2),
		.align_count (align_count)
	);

	////////////////////
	// ADC clock gate
	////////////////////

	// Gate only moves while clk357 is low, so no runt pulses
	always_ff @(negedge clk357) begin
		if (reset) begin
			run_n <= 1'b0;
		end else begin
			run_n <= run;
		end
	end

	assign adc_clk = clk357 & run_n; // First high phase on the next rising edge

endmodule

`default_nettype wire

// File: logic/aux_out_select.sv
`timescale 1ns/1ps
`default_nettype none

// Aux output routing for the two board variants
module aux_out_select
	import font5_io_pkg::*;
(
	input  wire  clk357,
	input  wire  reset,
	input  wire  font5_detect, // Pulled up on one variant, asynchronous
	input  wire  aux_out_a,
	input  wire  aux_out_b,
	output logic aux_out_a1,   // Non-inverting buffer pair
	output logic aux_out_b1,
	output logic aux_out_a2,   // Inverting buffer pair
	output logic aux_out_b2,
	output logic aux_oe1,
	output logic aux_oe2
);

	logic [sync_stages-1:0] detect_sync;
	logic                   detect_s;

	////////////////////
	// Detect synchroniser
	////////////////////

	always_ff @(posedge clk357) begin
		if (reset) begin
			detect_sync <= '0;
		end else begin
			detect_sync <= {detect_sync[sync_stages-2:0], font5_detect}; // Shift in at bit 0
		end
	end

	assign detect_s = detect_sync[sync_stages-1];

	////////////////////
	// Output pairs
	////////////////////

	always_ff @(posedge clk357) begin
		if (reset) begin
			aux_out_a1 <= 1'b0;
			aux_out_b1 <= 1'b0;
			aux_out_a2 <= 1'b0;
			aux_out_b2 <= 1'b0;
			aux_oe1    <= 1'b0;
			aux_oe2    <= 1'b0;
		end else begin
			// Idle pair parked low and undriven
			aux_out_a1 <= detect_s & aux_out_a;
			aux_out_b1 <= detect_s & aux_out_b;
			aux_out_a2 <= ~detect_s & ~aux_out_a; // Buffers invert again on the board
			aux_out_b2 <= ~detect_s & ~aux_out_b;
			aux_oe1    <= detect_s;
			aux_oe2    <= ~detect_s;
		end
	end

	// Both pairs driving at once would fight on the shared pads
	a_one_pair: assert property (
		@(posedge clk357) !(aux_oe1 && aux_oe2)
	) else $error("both aux output enables high");

endmodule

`default_nettype wire

// File: logic/font5_io_front.sv
`timescale 1ns/1ps
`default_nettype none

// I/O front end of the nine-channel board, clk357 domain only
module font5_io_front
	import font5_io_pkg::*;
(
	input  wire                   clk357,
	input  wire                   reset,

	// Control from the core
	input  wire                   run,
	input  wire                   iddr_ce,
	input  wire  [num_groups-1:0] delay_calc_strb,
	input  wire  [num_groups-1:0] delay_trig,
	input  wire  [num_groups-1:0] adc_clk_delay_ce,
	input  wire  [num_groups-1:0] adc_drdy_delay_ce,
	input  wire  [num_groups-1:0] adc_data_delay_ce,

	// Pads
	input  wire  [num_groups-1:0] drdy,         // One per group, first channel of each
	input  wire                   font5_detect,
	input  wire                   aux_out_a,
	input  wire                   aux_out_b,

	// Per group results
	output logic [num_groups-1:0] adc_clk,
	output tap_t                  clk_tap     [num_groups],
	output tap_t                  drdy_tap    [num_groups],
	output tap_t                  data_tap    [num_groups],
	output logic [num_groups-1:0] iddr_q1,
	output logic [num_groups-1:0] iddr_q2,
	output align_cnt_t            align_count [num_groups],

	// Aux pads, values plus enables
	output logic                  aux_out_a1,
	output logic                  aux_out_b1,
	output logic                  aux_out_a2,
	output logic                  aux_out_b2,
	output logic                  aux_oe1,
	output logic                  aux_oe2
);

	////////////////////
	// ADC groups
	////////////////////

	for (genvar g = 0; g < num_groups; g++) begin : g_group
		adc_group adc_group_i (
			.clk357          (clk357),
			.reset           (reset),
			.run             (run),                  // Shared by all groups
			.iddr_ce         (iddr_ce),
			.delay_calc_strb (delay_calc_strb[g]),
			.delay_trig      (delay_trig[g]),
			.clk_delay_ce    (adc_clk_delay_ce[g]),
			.drdy_delay_ce   (adc_drdy_delay_ce[g]),
			.data_delay_ce   (adc_data_delay_ce[g]),
			.drdy            (drdy[g]),
			.adc_clk         (adc_clk[g]),
			.clk_tap         (clk_tap[g]),
			.drdy_tap        (drdy_tap[g]),
			.data_tap        (data_tap[g]),
			.iddr_q1         (iddr_q1[g]),
			.iddr_q2         (iddr_q2[g]),
			.align_count     (align_count[g])
		);
	end

	////////////////////
	// Aux outputs
	////////////////////

	aux_out_select aux_sel_i (
		.clk357       (clk357),
		.reset        (reset),
		.font5_detect (font5_detect),
		.aux_out_a    (aux_out_a),
		.aux_out_b    (aux_out_b),
		.aux_out_a1   (aux_out_a1),
		.aux_out_b1   (aux_out_b1),
		.aux_out_a2   (aux_out_a2),
		.aux_out_b2   (aux_out_b2),
		.aux_oe1      (aux_oe1),
		.aux_oe2      (aux_oe2)
	);

endmodule

`default_nettype wire

// File: dv/font5_io_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module font5_io_front_tb
	import font5_io_pkg::*;
();

	localparam int clk_period   = 40;
	localparam int reset_cycles = 10;
	localparam int idle_cycles  = 5;  // adc_clk must stay low here
	localparam int wrap_cycles  = 70; // Enough steps to roll every tap past 63
	localparam int rand_cycles  = 600;
	localparam int tail_cycles  = 5;
	localparam int margin       = 100;
	localparam int total_cycles = reset_cycles + idle_cycles + wrap_cycles
		+ rand_cycles + tail_cycles;
	localparam int watchdog_ns  = (total_cycles + margin) * clk_period;
	localparam int unsigned rng_seed = 68422;

	logic                  clk357;
	logic                  reset;
	logic                  run;
	logic                  iddr_ce;
	logic [num_groups-1:0] delay_calc_strb;
	logic [num_groups-1:0] delay_trig;
	logic [num_groups-1:0] adc_clk_delay_ce;
	logic [num_groups-1:0] adc_drdy_delay_ce;
	logic [num_groups-1:0] adc_data_delay_ce;
	logic [num_groups-1:0] drdy;
	logic                  font5_detect;
	logic                  aux_out_a;
	logic                  aux_out_b;
	logic [num_groups-1:0] adc_clk;
	tap_t                  clk_tap [num_groups];
	tap_t                  drdy_tap [num_groups];
	tap_t                  data_tap [num_groups];
	logic [num_groups-1:0] iddr_q1;
	logic [num_groups-1:0] iddr_q2;
	align_cnt_t            align_count [num_groups];
	logic                  aux_out_a1;
	logic                  aux_out_b1;
	logic                  aux_out_a2;
	logic                  aux_out_b2;
	logic                  aux_oe1;
	logic                  aux_oe2;

	// Model state
	tap_t                  exp_clk_tap [num_groups];
	tap_t                  exp_drdy_tap [num_groups];
	tap_t                  exp_data_tap [num_groups];
	align_cnt_t            exp_count [num_groups];
	logic [num_groups-1:0] fall_cap;    // Early half taken at the falling edge
	logic [num_groups-1:0] stage_early; // Pair one edge in flight
	logic [num_groups-1:0] stage_late;
	logic [num_groups-1:0] exp_q1;
	logic [num_groups-1:0] exp_q2;
	logic                  exp_run;     // run as seen at the last falling edge
	logic [1:0]            exp_det;     // Detect history with the oldest in [1]
	logic [5:0]            exp_aux;     // {a1, b1, a2, b2, oe1, oe2}
	logic                  checks_on;

	font5_io_front dut_i (.*);

	////////////////////
	// Clock, drdy, watchdog
	////////////////////

	initial begin
		clk357 = 1'b0;
		forever #(clk_period / 2) clk357 = ~clk357;
	end

	// New drdy value each half cycle so the two halves can differ
	always @(posedge clk357 or negedge clk357) begin
		#2;
		drdy = num_groups'($urandom);
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog timeout: stimulus did not finish within %0d ns", watchdog_ns);
		$display("Verification failed");
		$fatal(1, "timeout");
	end

	////////////////////
	// Reference functions
	////////////////////

	function automatic tap_t tap_ref(tap_t cur, logic clr, logic ce);
		if (clr)
			return '0; // Clear beats a step
		if (ce)
			return (cur == tap_max) ? tap_t'(0) : tap_t'(cur + 1); // Line wraps
		return cur;
	endfunction

	function automatic align_cnt_t count_ref(align_cnt_t cur, logic clr, logic q1, logic q2);
		if (clr)
			return '0;
		if ((q1 != q2) && (cur != '1))
			return align_cnt_t'(cur + 1); // Saturates at full scale
		return cur;
	endfunction

	// Straight pair with detect high and inverted pair with detect low
	function automatic logic [5:0] aux_ref(logic det, logic a, logic b);
		if (det)
			return {a, b, 1'b0, 1'b0, 1'b1, 1'b0};
		return {1'b0, 1'b0, ~a, ~b, 1'b0, 1'b1};
	endfunction

	function automatic logic [num_groups-1:0] sparse_bits(int unsigned odds);
		logic [num_groups-1:0] bits;
		for (int g = 0; g < num_groups; g++)
			bits[g] = (($urandom % odds) == 0); // One in odds
		return bits;
	endfunction

	////////////////////
	// Model
	////////////////////

	always @(negedge clk357) begin
		if (reset) begin
			fall_cap = '0;
			exp_run  = 1'b0;
		end else begin
			if (iddr_ce)
				fall_cap = drdy;
			exp_run = run;
		end
	end

	always @(posedge clk357) begin
		logic clr;
		if (reset) begin
			for (int g = 0; g < num_groups; g++) begin
				exp_clk_tap[g]  = '0;
				exp_drdy_tap[g] = '0;
				exp_data_tap[g] = '0;
				exp_count[g]    = '0;
			end
			stage_early = '0;
			stage_late  = '0;
			exp_q1      = '0;
			exp_q2      = '0;
			exp_det     = '0;
			exp_aux     = '0;
		end else begin
			for (int g = 0; g < num_groups; g++) begin
				clr = delay_calc_strb[g] | delay_trig[g]; // Shared by all three lines
				exp_clk_tap[g]  = tap_ref(exp_clk_tap[g], clr, adc_clk_delay_ce[g]);
				exp_drdy_tap[g] = tap_ref(exp_drdy_tap[g], clr, adc_drdy_delay_ce[g]);
				exp_data_tap[g] = tap_ref(exp_data_tap[g], clr, adc_data_delay_ce[g]);
				// Count looks at the pair shown before this edge
				exp_count[g] = count_ref(exp_count[g], delay_calc_strb[g], exp_q1[g], exp_q2[g]);
			end
			if (iddr_ce) begin
				exp_q1      = stage_late;  // Two edges after capture
				exp_q2      = stage_early;
				stage_late  = drdy;
				stage_early = fall_cap;
			end
			exp_aux = aux_ref(exp_det[1], aux_out_a, aux_out_b);
			exp_det = {exp_det[0], font5_detect};
		end
	end

	////////////////////
	// Compare
	////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clk357) begin
		#10; // Mid high phase
		if (checks_on) begin
			for (int g = 0; g < num_groups; g++) begin
				check_value($sformatf("clk_tap[%0d]", g), 32'(clk_tap[g]), 32'(exp_clk_tap[g]));
				check_value($sformatf("drdy_tap[%0d]", g), 32'(drdy_tap[g]), 32'(exp_drdy_tap[g]));
				check_value($sformatf("data_tap[%0d]", g), 32'(data_tap[g]), 32'(exp_data_tap[g]));
				check_value($sformatf("iddr_q1[%0d]", g), 32'(iddr_q1[g]), 32'(exp_q1[g]));
				check_value($sformatf("iddr_q2[%0d]", g), 32'(iddr_q2[g]), 32'(exp_q2[g]));
				check_value($sformatf("align_count[%0d]", g), 32'(align_count[g]),
					32'(exp_count[g]));
			end
			check_value("adc_clk high phase", 32'(adc_clk), 32'({num_groups{exp_run}}));
			check_value("aux outputs", 32'({aux_out_a1, aux_out_b1, aux_out_a2, aux_out_b2,
				aux_oe1, aux_oe2}), 32'(exp_aux));
			#20;
			check_value("adc_clk low phase", 32'(adc_clk), 32'(0)); // Gate never leaks
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		void'($urandom(rng_seed));
		reset             = 1'b1;
		run               = 1'b0;
		iddr_ce           = 1'b0;
		delay_calc_strb   = '0;
		delay_trig        = '0;
		adc_clk_delay_ce  = '0;
		adc_drdy_delay_ce = '0;
		adc_data_delay_ce = '0;
		drdy              = '0;
		font5_detect      = 1'b0;
		aux_out_a         = 1'b0;
		aux_out_b         = 1'b0;
		checks_on         = 1'b0;

		repeat (2) @(posedge clk357);
		#2;
		checks_on = 1'b1; // Negedge flops reset by now
		repeat (reset_cycles - 2) @(posedge clk357);
		#2;
		reset = 1'b0;
		repeat (idle_cycles) @(posedge clk357);

		// Steady stepping wraps every tap once
		for (int i = 0; i < wrap_cycles; i++) begin
			#2;
			run               = 1'b1;
			iddr_ce           = 1'b1;
			font5_detect      = 1'b1;
			adc_clk_delay_ce  = '1;
			adc_drdy_delay_ce = '1;
			adc_data_delay_ce = '1;
			aux_out_a         = 1'($urandom);
			aux_out_b         = 1'($urandom);
			delay_calc_strb   = (i == wrap_cycles - 3) ? 3'b101 : 3'b000; // Clear with step
			delay_trig        = (i == wrap_cycles - 3) ? 3'b010 : 3'b000;
			@(posedge clk357);
		end

		for (int i = 0; i < rand_cycles; i++) begin
			#2;
			delay_calc_strb   = sparse_bits(16);
			delay_trig        = sparse_bits(24);
			adc_clk_delay_ce  = sparse_bits(2);
			adc_drdy_delay_ce = sparse_bits(2);
			adc_data_delay_ce = sparse_bits(2);
			iddr_ce           = (($urandom % 8) != 0); // Mostly enabled
			aux_out_a         = 1'($urandom);
			aux_out_b         = 1'($urandom);
			if (($urandom % 16) == 0)
				run = ~run;
			if (($urandom % 32) == 0)
				font5_detect = ~font5_detect; // Variant swap
			@(posedge clk357);
		end

		#2;
		delay_calc_strb   = '0;
		delay_trig        = '0;
		adc_clk_delay_ce  = '0;
		adc_drdy_delay_ce = '0;
		adc_data_delay_ce = '0;
		run               = 1'b0;
		repeat (tail_cycles) @(posedge clk357);
		#15;

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/font5_io_pkg.sv
logic/idelay_tap_counter.sv
logic/drdy_iddr.sv
logic/drdy_align_monitor.sv
logic/adc_group.sv
logic/aux_out_select.sv
logic/font5_io_front.sv
dv/font5_io_front_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module font5_io_front_tb \
	-f sources.f \
	-o font5_io_front_tb

./obj_dir/font5_io_front_tb | tee sim.log

if grep -q "^Verification passed$" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
